/* all.f */
+incdir+include
verilog/mmu_pkg.sv
verilog/tlb.sv
verilog/ptw.sv
verilog/mmu_resp.sv
verilog/mmu_top.sv
verif/mmu_sva.sv
verif/tb_mmu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mmu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/tb_mmu_cfg.svh */
`ifndef TB_MMU_CFG_SVH
`define TB_MMU_CFG_SVH

// Root page table base used by every test
`define TB_SATP_PPN 22'h00100

// Leaf tables start at this PPN, one table per VPN[1]
`define TB_L2_BASE 22'h00200

// PTE flag bits
`define PTE_V 8'h01
`define PTE_R 8'h02
`define PTE_W 8'h04
`define PTE_X 8'h08
`define PTE_A 8'h40
`define PTE_D 8'h80

`endif

/* verif/tb_mmu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_cfg.svh"
`include "tb_mmu_cfg.svh"

module tb_mmu;

    localparam int NUM_TESTS = 13;

    logic               clk;
    logic               rst_n;
    logic               i_req_i;
    logic [`VALEN-1:0]  i_vaddr_i;
    logic               d_req_i;
    logic [`VALEN-1:0]  d_vaddr_i;
    logic               d_store_i;
    logic [`PPN_W-1:0]  satp_ppn_i;
    logic               mxr_i;
    logic               flush_i;
    logic               i_resp_valid_o;
    logic [`PALEN-1:0]  i_paddr_o;
    logic               i_fault_o;
    logic               d_resp_valid_o;
    logic [`PALEN-1:0]  d_paddr_o;
    logic               d_fault_o;
    logic               mem_req_o;
    logic [`PALEN-1:0]  mem_paddr_o;
    logic               mem_rvalid_i;
    logic [`XLEN-1:0]   mem_rdata_i;
    logic               walk_active_o;

    // Page table memory, keyed by physical byte address
    logic [31:0] pt_mem [logic [33:0]];
    logic [33:0] read_log [$];
    int          reads;
    int          errors;
    int          test_errs;
    int          tests_run;
    int          tests_bad;

    mmu_top u_mmu_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_req_i        (i_req_i),
        .i_vaddr_i      (i_vaddr_i),
        .d_req_i        (d_req_i),
        .d_vaddr_i      (d_vaddr_i),
        .d_store_i      (d_store_i),
        .satp_ppn_i     (satp_ppn_i),
        .mxr_i          (mxr_i),
        .flush_i        (flush_i),
        .i_resp_valid_o (i_resp_valid_o),
        .i_paddr_o      (i_paddr_o),
        .i_fault_o      (i_fault_o),
        .d_resp_valid_o (d_resp_valid_o),
        .d_paddr_o      (d_paddr_o),
        .d_fault_o      (d_fault_o),
        .mem_req_o      (mem_req_o),
        .mem_paddr_o    (mem_paddr_o),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .walk_active_o  (walk_active_o)
    );

    always #10 clk = ~clk;

    // Memory model answers a request two cycles later with a one-cycle strobe
    always begin
        logic [33:0] addr;
        @(posedge clk);
        #1;
        if (rst_n && mem_req_o) begin
            addr = mem_paddr_o;
            repeat (2) @(posedge clk);
            #1;
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = pt_mem.exists(addr) ? pt_mem[addr] : 32'h0;
            read_log.push_back(addr);
            reads++;
            @(posedge clk);
            #1;
            mem_rvalid_i = 1'b0;
            @(posedge clk);
        end
    end

    initial begin
        #(NUM_TESTS * 2000);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic logic [21:0] l2_ppn(input logic [9:0] vpn1);
        return `TB_L2_BASE | {12'h000, vpn1};
    endfunction

    function automatic logic [33:0] l1_addr(input logic [9:0] vpn1);
        return {`TB_SATP_PPN, vpn1, 2'b00};
    endfunction

    function automatic logic [33:0] leaf_addr(input logic [9:0] vpn1, input logic [9:0] vpn0);
        return {l2_ppn(vpn1), vpn0, 2'b00};
    endfunction

    task automatic map_4k(input logic [9:0] vpn1, input logic [9:0] vpn0,
                          input logic [21:0] ppn, input logic [7:0] flags);
        pt_mem[l1_addr(vpn1)]         = make_pte(l2_ppn(vpn1), `PTE_V);
        pt_mem[leaf_addr(vpn1, vpn0)] = make_pte(ppn, flags);
    endtask

    task automatic map_4m(input logic [9:0] vpn1, input logic [21:0] ppn,
                          input logic [7:0] flags);
        pt_mem[l1_addr(vpn1)] = make_pte(ppn, flags);
    endtask

    task automatic check_val(input string sig, input logic [33:0] exp, input logic [33:0] got);
        if (exp !== got) begin
            $display("Fail %s exp %h got %h", sig, exp, got);
            errors++;
        end
    endtask

    task automatic check_reads(input int exp, input int got);
        if (exp != got) begin
            $display("Expected %0d page table reads but saw %0d", exp, got);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_errs) begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - test_errs);
        end else begin
            $display("%s: ok", name);
        end
        test_errs = errors;
    endtask

    // Sends one request and waits for its strobe; cycles counts edges after the request
    task automatic translate(input bit port, input logic [31:0] va, input bit store,
                             output bit fault, output logic [33:0] pa, output int cycles);
        bit done;
        done   = 1'b0;
        fault  = 1'b0;
        pa     = '0;
        cycles = 0;
        if (port) begin
            d_req_i   = 1'b1;
            d_vaddr_i = va;
            d_store_i = store;
        end else begin
            i_req_i   = 1'b1;
            i_vaddr_i = va;
        end
        @(posedge clk);
        #1;
        i_req_i = 1'b0;
        d_req_i = 1'b0;
        while (!done && cycles < 300) begin
            @(posedge clk);
            #1;
            cycles++;
            if (port ? (d_resp_valid_o || d_fault_o) : (i_resp_valid_o || i_fault_o)) begin
                done  = 1'b1;
                fault = port ? d_fault_o : i_fault_o;
                pa    = port ? d_paddr_o : i_paddr_o;
            end
        end
        if (!done) begin
            $display("No response on port %0d for vaddr %h", port, va);
            errors++;
        end
    endtask

    task automatic expect_ok(input bit port, input logic [31:0] va, input bit store,
                             input logic [33:0] exp_pa, input int exp_reads);
        bit          fault;
        logic [33:0] pa;
        int          cycles;
        int          r0;
        r0 = reads;
        translate(port, va, store, fault, pa, cycles);
        check_val(port ? "d_fault_o" : "i_fault_o", 34'h0, {33'h0, fault});
        check_val(port ? "d_paddr_o" : "i_paddr_o", exp_pa, pa);
        check_reads(exp_reads, reads - r0);
    endtask

    // A fault fills nothing, so the second request walks again
    task automatic fault_twice(input string name, input bit port, input logic [31:0] va,
                               input bit store, input int walk_reads);
        bit          fault;
        logic [33:0] pa;
        int          cycles;
        int          r0;
        r0 = reads;
        for (int k = 0; k < 2; k++) begin
            translate(port, va, store, fault, pa, cycles);
            check_val(port ? "d_fault_o" : "i_fault_o", 34'h1, {33'h0, fault});
        end
        check_reads(2 * walk_reads, reads - r0);
        end_test(name);
    endtask

    task automatic test_fetch_4k();
        bit          fault;
        logic [33:0] pa;
        int          cycles;
        int          r0;
        map_4k(10'd1, 10'd1, 22'h12345, `PTE_V | `PTE_R | `PTE_X | `PTE_A);
        expect_ok(1'b0, {10'd1, 10'd1, 12'habc}, 1'b0, {22'h12345, 12'habc}, 2);
        r0 = reads;
        translate(1'b0, {10'd1, 10'd1, 12'h004}, 1'b0, fault, pa, cycles);
        check_val("i_paddr_o", {22'h12345, 12'h004}, pa);
        if (cycles != 1) begin
            $display("TLB hit took %0d cycles instead of 1", cycles);
            errors++;
        end
        check_reads(0, reads - r0);
        end_test("fetch_4k");
    endtask

    task automatic test_superpage();
        map_4m(10'd2, 22'h00c00, `PTE_V | `PTE_R | `PTE_A);
        expect_ok(1'b1, {10'd2, 22'h034567}, 1'b0, {12'h003, 22'h034567}, 1);
        end_test("superpage");
    endtask

    task automatic test_both_ports();
        bit got_i;
        bit got_d;
        int cycles;
        map_4k(10'd10, 10'd3, 22'h0aaaa, `PTE_V | `PTE_X | `PTE_A);
        map_4k(10'd11, 10'd4, 22'h0bbbb, `PTE_V | `PTE_R | `PTE_A);
        read_log.delete();
        got_i     = 1'b0;
        got_d     = 1'b0;
        cycles    = 0;
        i_req_i   = 1'b1;
        i_vaddr_i = {10'd10, 10'd3, 12'h111};
        d_req_i   = 1'b1;
        d_vaddr_i = {10'd11, 10'd4, 12'h222};
        d_store_i = 1'b0;
        @(posedge clk);
        #1;
        i_req_i = 1'b0;
        d_req_i = 1'b0;
        while (!(got_i && got_d) && cycles < 300) begin
            @(posedge clk);
            #1;
            cycles++;
            if (i_resp_valid_o || i_fault_o) begin
                got_i = 1'b1;
                check_val("i_fault_o", 34'h0, {33'h0, i_fault_o});
                check_val("i_paddr_o", {22'h0aaaa, 12'h111}, i_paddr_o);
            end
            if (d_resp_valid_o || d_fault_o) begin
                got_d = 1'b1;
                check_val("d_fault_o", 34'h0, {33'h0, d_fault_o});
                check_val("d_paddr_o", {22'h0bbbb, 12'h222}, d_paddr_o);
            end
        end
        if (!(got_i && got_d)) begin
            $display("Both-port miss was not answered on both ports");
            errors++;
        end
        check_reads(4, read_log.size());
        if (read_log.size() >= 2) begin
            check_val("mem_paddr_o", l1_addr(10'd10), read_log[0]);
            check_val("mem_paddr_o", leaf_addr(10'd10, 10'd3), read_log[1]);
        end
        end_test("both_ports");
    endtask

    task automatic test_flush_after_fill();
        flush_i = 1'b1;
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        expect_ok(1'b0, {10'd1, 10'd1, 12'h008}, 1'b0, {22'h12345, 12'h008}, 2);
        end_test("flush_after_fill");
    endtask

    task automatic test_flush_mid_walk();
        int  r0;
        int  cycles;
        int  after;
        bit  returned;
        bit  dropped;
        map_4k(10'd12, 10'd5, 22'h0cccc, `PTE_V | `PTE_R | `PTE_A);
        returned  = 1'b0;
        dropped   = 1'b0;
        after     = 0;
        cycles    = 0;
        d_req_i   = 1'b1;
        d_vaddr_i = {10'd12, 10'd5, 12'h333};
        d_store_i = 1'b0;
        @(posedge clk);
        #1;
        d_req_i = 1'b0;
        while (!mem_req_o && cycles < 20) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        r0 = reads;
        @(posedge clk);
        #1;
        flush_i = 1'b1;
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        #1;
        // Sampled 2 ns after each edge, from the cycle the flush is taken
        for (int k = 0; k < 40; k++) begin
            if (i_resp_valid_o || i_fault_o || d_resp_valid_o || d_fault_o) begin
                $display("Response strobe after a flush in the middle of a walk");
                errors++;
            end
            if (!returned) begin
                if (!mem_req_o) begin
                    $display("mem_req_o fell before the outstanding read returned");
                    errors++;
                end
                returned = (reads != r0);
            end else if (!dropped) begin
                after++;
                dropped = !mem_req_o;
            end
            @(posedge clk);
            #2;
        end
        if (!returned || !dropped || after > 3) begin
            $display("mem_req_o did not fall shortly after the outstanding read");
            errors++;
        end
        check_val("walk_active_o", 34'h0, {33'h0, walk_active_o});
        end_test("flush_mid_walk");
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        i_req_i      = 1'b0;
        i_vaddr_i    = '0;
        d_req_i      = 1'b0;
        d_vaddr_i    = '0;
        d_store_i    = 1'b0;
        satp_ppn_i   = `TB_SATP_PPN;
        mxr_i        = 1'b0;
        flush_i      = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        reads        = 0;
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_bad    = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        test_fetch_4k();
        test_superpage();
        map_4m(10'd3, 22'h00c01, `PTE_V | `PTE_R | `PTE_A);
        fault_twice("misaligned_superpage", 1'b1, {10'd3, 22'h000010}, 1'b0, 1);
        fault_twice("invalid_pte", 1'b1, {10'd4, 22'h000020}, 1'b0, 1);
        map_4k(10'd5, 10'd1, 22'h05555, `PTE_V | `PTE_W | `PTE_A);
        fault_twice("write_no_read", 1'b1, {10'd5, 10'd1, 12'h030}, 1'b0, 2);
        map_4k(10'd6, 10'd1, 22'h06666, `PTE_V);
        fault_twice("pointer_at_level2", 1'b1, {10'd6, 10'd1, 12'h040}, 1'b0, 2);
        map_4k(10'd7, 10'd1, 22'h07777, `PTE_V | `PTE_R | `PTE_A);
        fault_twice("fetch_no_exec", 1'b0, {10'd7, 10'd1, 12'h050}, 1'b0, 2);
        map_4k(10'd8, 10'd1, 22'h08888, `PTE_V | `PTE_R | `PTE_W | `PTE_A);
        fault_twice("store_clean_page", 1'b1, {10'd8, 10'd1, 12'h060}, 1'b1, 2);

        // Execute-only page, readable only with MXR
        map_4k(10'd9, 10'd1, 22'h09999, `PTE_V | `PTE_X | `PTE_A);
        mxr_i = 1'b0;
        fault_twice("load_exec_only", 1'b1, {10'd9, 10'd1, 12'h070}, 1'b0, 2);
        mxr_i = 1'b1;
        expect_ok(1'b1, {10'd9, 10'd1, 12'h070}, 1'b0, {22'h09999, 12'h070}, 2);
        mxr_i = 1'b0;
        end_test("load_with_mxr");

        test_both_ports();
        test_flush_after_fill();
        test_flush_mid_walk();

        $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/mmu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_sva (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic mem_req_o,
    input wire logic mem_rvalid_i,
    input wire logic i_resp_valid_o,
    input wire logic i_fault_o,
    input wire logic d_resp_valid_o,
    input wire logic d_fault_o
);

    // Memory request is held until the read comes back
    // The walker registers rvalid, so the request still stands in the cycle after it
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_o && !mem_rvalid_i && !$past(mem_rvalid_i)) |=> mem_req_o)
        else $error("mem_req_o dropped before mem_rvalid_i");

    a_i_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_resp_valid_o && i_fault_o))
        else $error("instruction response and fault together");

    a_d_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(d_resp_valid_o && d_fault_o))
        else $error("data response and fault together");

    // Nothing may strobe while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !(i_resp_valid_o || i_fault_o || d_resp_valid_o || d_fault_o || mem_req_o))
        else $error("strobe high during reset");

endmodule

bind mmu_top mmu_sva u_mmu_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_req_o      (mem_req_o),
    .mem_rvalid_i   (mem_rvalid_i),
    .i_resp_valid_o (i_resp_valid_o),
    .i_fault_o      (i_fault_o),
    .d_resp_valid_o (d_resp_valid_o),
    .d_fault_o      (d_fault_o)
);

`default_nettype wire

/* verilog/mmu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_cfg.svh"

module mmu_top
    import mmu_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_req_i,
    input  logic [`VALEN-1:0]   i_vaddr_i,
    input  logic                d_req_i,
    input  logic [`VALEN-1:0]   d_vaddr_i,
    input  logic                d_store_i,
    input  logic [`PPN_W-1:0]   satp_ppn_i,
    input  logic                mxr_i,
    input  logic                flush_i,
    output logic                i_resp_valid_o,
    output logic [`PALEN-1:0]   i_paddr_o,
    output logic                i_fault_o,
    output logic                d_resp_valid_o,
    output logic [`PALEN-1:0]   d_paddr_o,
    output logic                d_fault_o,
    output logic                mem_req_o,
    output logic [`PALEN-1:0]   mem_paddr_o,
    input  logic                mem_rvalid_i,
    input  logic [`XLEN-1:0]    mem_rdata_i,
    output logic                walk_active_o
);

    logic [`NUM_PORTS-1:0][`VALEN-13:0] lookup_vpn;
    logic [`NUM_PORTS-1:0]              tlb_hit;
    tlb_entry_t [`NUM_PORTS-1:0]        tlb_hit_entry;
    logic [`NUM_PORTS-1:0]              pend;
    logic [`NUM_PORTS-1:0][`VALEN-13:0] pend_vpn;
    logic                               pend_store;
    logic [`NUM_PORTS-1:0]              fill;
    tlb_entry_t                         fill_entry;
    logic [`NUM_PORTS-1:0]              walk_err;

    mmu_resp u_mmu_resp (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush_i),
        .i_req_i         (i_req_i),
        .i_vaddr_i       (i_vaddr_i),
        .d_req_i         (d_req_i),
        .d_vaddr_i       (d_vaddr_i),
        .d_store_i       (d_store_i),
        .tlb_hit_i       (tlb_hit),
        .tlb_hit_entry_i (tlb_hit_entry),
        .walk_err_i      (walk_err),
        .lookup_vpn_o    (lookup_vpn),
        .pend_o          (pend),
        .pend_vpn_o      (pend_vpn),
        .pend_store_o    (pend_store),
        .i_resp_valid_o  (i_resp_valid_o),
        .i_paddr_o       (i_paddr_o),
        .i_fault_o       (i_fault_o),
        .d_resp_valid_o  (d_resp_valid_o),
        .d_paddr_o       (d_paddr_o),
        .d_fault_o       (d_fault_o)
    );

    // ITLB at index 0, DTLB at index 1
    for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_tlb
        tlb u_tlb (
            .clk          (clk),
            .rst_n        (rst_n),
            .flush_i      (flush_i),
            .fill_i       (fill[g]),
            .fill_entry_i (fill_entry),
            .lookup_vpn_i (lookup_vpn[g]),
            .hit_o        (tlb_hit[g]),
            .hit_entry_o  (tlb_hit_entry[g])
        );
    end

    ptw u_ptw (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .pend_i        (pend),
        .pend_vpn_i    (pend_vpn),
        .tlb_hit_i     (tlb_hit),
        .d_store_i     (pend_store),
        .satp_ppn_i    (satp_ppn_i),
        .mxr_i         (mxr_i),
        .mem_req_o     (mem_req_o),
        .mem_paddr_o   (mem_paddr_o),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rdata_i   (mem_rdata_i),
        .fill_o        (fill),
        .fill_entry_o  (fill_entry),
        .walk_err_o    (walk_err),
        .walk_active_o (walk_active_o)
    );

endmodule

`default_nettype wire

/* verilog/mmu_resp.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_cfg.svh"

module mmu_resp
    import mmu_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 flush_i,
    input  logic                                 i_req_i,
    input  logic [`VALEN-1:0]                    i_vaddr_i,
    input  logic                                 d_req_i,
    input  logic [`VALEN-1:0]                    d_vaddr_i,
    input  logic                                 d_store_i,
    input  logic [`NUM_PORTS-1:0]                tlb_hit_i,
    input  tlb_entry_t [`NUM_PORTS-1:0]          tlb_hit_entry_i,
    input  logic [`NUM_PORTS-1:0]                walk_err_i,
    output logic [`NUM_PORTS-1:0][`VALEN-13:0]   lookup_vpn_o,
    output logic [`NUM_PORTS-1:0]                pend_o,
    output logic [`NUM_PORTS-1:0][`VALEN-13:0]   pend_vpn_o,
    output logic                                 pend_store_o,
    output logic                                 i_resp_valid_o,
    output logic [`PALEN-1:0]                    i_paddr_o,
    output logic                                 i_fault_o,
    output logic                                 d_resp_valid_o,
    output logic [`PALEN-1:0]                    d_paddr_o,
    output logic                                 d_fault_o
);

    logic [`NUM_PORTS-1:0]               req;
    logic [`NUM_PORTS-1:0][`VALEN-1:0]   req_vaddr;
    logic [`NUM_PORTS-1:0]               pend_q;
    logic [`NUM_PORTS-1:0][`VALEN-1:0]   vaddr_q;
    logic                                store_q;
    logic [`NUM_PORTS-1:0][`PALEN-1:0]   paddr_hit;
    logic [`NUM_PORTS-1:0][`PALEN-1:0]   paddr_q;
    logic [`NUM_PORTS-1:0]               resp_q;
    logic [`NUM_PORTS-1:0]               fault_q;

    // Index 0 is the instruction port, index 1 the data port
    assign req       = {d_req_i, i_req_i};
    assign req_vaddr = {d_vaddr_i, i_vaddr_i};

    always_comb begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            lookup_vpn_o[p] = vaddr_q[p][`VALEN-1:12];
            pend_vpn_o[p]   = vaddr_q[p][`VALEN-1:12];
            if (tlb_hit_entry_i[p].page_4m) begin
                paddr_hit[p] = {tlb_hit_entry_i[p].pte.ppn[21:10], vaddr_q[p][21:0]};
            end else begin
                paddr_hit[p] = {tlb_hit_entry_i[p].pte.ppn, vaddr_q[p][11:0]};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q  <= '0;
            resp_q  <= '0;
            fault_q <= '0;
        end else begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                resp_q[p]  <= 1'b0;
                fault_q[p] <= 1'b0;
                if (flush_i) begin
                    // Dropped silently
                    pend_q[p] <= 1'b0;
                end else if (pend_q[p]) begin
                    if (tlb_hit_i[p]) begin
                        resp_q[p] <= 1'b1;
                        pend_q[p] <= 1'b0;
                    end else if (walk_err_i[p]) begin
                        fault_q[p] <= 1'b1;
                        pend_q[p]  <= 1'b0;
                    end
                end else if (req[p]) begin
                    pend_q[p] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (!pend_q[p] && req[p]) begin
                vaddr_q[p] <= req_vaddr[p];
            end
            if (pend_q[p] && tlb_hit_i[p]) begin
                paddr_q[p] <= paddr_hit[p];
            end
        end
        if (!pend_q[1] && d_req_i) begin
            store_q <= d_store_i;
        end
    end

    assign pend_o       = pend_q;
    assign pend_store_o = store_q;

    assign i_resp_valid_o = resp_q[0];
    assign i_paddr_o      = paddr_q[0];
    assign i_fault_o      = fault_q[0];
    assign d_resp_valid_o = resp_q[1];
    assign d_paddr_o      = paddr_q[1];
    assign d_fault_o      = fault_q[1];

endmodule

`default_nettype wire

/* verilog/ptw.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_cfg.svh"

module ptw
    import mmu_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 flush_i,
    input  logic [`NUM_PORTS-1:0]                pend_i,
    input  logic [`NUM_PORTS-1:0][`VALEN-13:0]   pend_vpn_i,
    input  logic [`NUM_PORTS-1:0]                tlb_hit_i,
    input  logic                                 d_store_i,
    input  logic [`PPN_W-1:0]                    satp_ppn_i,
    input  logic                                 mxr_i,
    output logic                                 mem_req_o,
    output logic [`PALEN-1:0]                    mem_paddr_o,
    input  logic                                 mem_rvalid_i,
    input  logic [`XLEN-1:0]                     mem_rdata_i,
    output logic [`NUM_PORTS-1:0]                fill_o,
    output tlb_entry_t                           fill_entry_o,
    output logic [`NUM_PORTS-1:0]                walk_err_o,
    output logic                                 walk_active_o
);

    ptw_state_e          state_q, state_d;
    ptw_level_e          level_q, level_d;
    // High while the walk serves the data port
    logic                walk_d_q, walk_d_d;
    logic                gmap_q, gmap_d;
    logic [`VALEN-13:0]  vpn_q, vpn_d;
    logic [`PALEN-1:0]   paddr_q, paddr_d;
    logic                req_q, req_d;
    logic [`XLEN-1:0]    rdata_q;
    logic                rvalid_q;
    logic [`NUM_PORTS-1:0] miss;
    logic [`VALEN-13:0]  start_vpn;
    logic                leaf_ok;
    logic                fill_en;
    logic                err_en;
    pte_sv32_t           pte;

    assign pte  = pte_sv32_t'(rdata_q);
    assign miss = pend_i & ~tlb_hit_i;

    // Instruction port has priority
    assign start_vpn = miss[0] ? pend_vpn_i[0] : pend_vpn_i[1];

    always_comb begin
        state_d  = state_q;
        level_d  = level_q;
        walk_d_d = walk_d_q;
        gmap_d   = gmap_q;
        vpn_d    = vpn_q;
        paddr_d  = paddr_q;
        req_d    = req_q;
        leaf_ok  = 1'b0;
        fill_en  = 1'b0;
        err_en   = 1'b0;

        case (state_q)
            PTW_IDLE: begin
                level_d = LEVEL_1;
                gmap_d  = 1'b0;
                if (|miss) begin
                    walk_d_d = ~miss[0];
                    vpn_d    = start_vpn;
                    // Root PTE at satp base plus VPN[1] * 4
                    paddr_d  = {satp_ppn_i, start_vpn[19:10], 2'b00};
                    req_d    = 1'b1;
                    state_d  = PTW_PROCESS_PTE;
                end
            end

            PTW_PROCESS_PTE: begin
                if (rvalid_q) begin
                    req_d   = 1'b0;
                    gmap_d  = gmap_q | pte.g;
                    state_d = PTW_IDLE;

                    if (!pte.v || (pte.w && !pte.r)) begin
                        state_d = PTW_PAGE_ERR;
                    end else if (pte.r || pte.x) begin
                        // Leaf PTE
                        if (!walk_d_q) begin
                            leaf_ok = pte.x && pte.a;
                        end else begin
                            leaf_ok = pte.a && (pte.r || (pte.x && mxr_i));
                            if (d_store_i && (!pte.w || !pte.d)) begin
                                leaf_ok = 1'b0;
                            end
                        end
                        // Misaligned superpage
                        if ((level_q == LEVEL_1) && (pte.ppn[9:0] != '0)) begin
                            leaf_ok = 1'b0;
                        end
                        if (leaf_ok) begin
                            fill_en = 1'b1;
                        end else begin
                            state_d = PTW_PAGE_ERR;
                        end
                    end else if (level_q == LEVEL_1) begin
                        // Pointer to the leaf table
                        level_d = LEVEL_2;
                        paddr_d = {pte.ppn, vpn_q[9:0], 2'b00};
                        req_d   = 1'b1;
                        state_d = PTW_PROCESS_PTE;
                    end else begin
                        // No pointers allowed below level 2
                        state_d = PTW_PAGE_ERR;
                    end
                end
            end

            PTW_PAGE_ERR: begin
                err_en  = 1'b1;
                state_d = PTW_IDLE;
            end

            PTW_WAIT_R_VALID: begin
                if (rvalid_q) begin
                    req_d   = 1'b0;
                    state_d = PTW_IDLE;
                end
            end

            default: begin
                state_d = PTW_IDLE;
            end
        endcase

        // A flush drops the walk but lets an outstanding read finish
        if (flush_i) begin
            fill_en = 1'b0;
            err_en  = 1'b0;
            if ((state_q inside {PTW_PROCESS_PTE, PTW_WAIT_R_VALID}) && !rvalid_q) begin
                state_d = PTW_WAIT_R_VALID;
                req_d   = 1'b1;
            end else begin
                state_d = PTW_IDLE;
                req_d   = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= PTW_IDLE;
            level_q  <= LEVEL_1;
            walk_d_q <= 1'b0;
            gmap_q   <= 1'b0;
            req_q    <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            level_q  <= level_d;
            walk_d_q <= walk_d_d;
            gmap_q   <= gmap_d;
            req_q    <= req_d;
            rvalid_q <= mem_rvalid_i;
        end
    end

    always_ff @(posedge clk) begin
        vpn_q   <= vpn_d;
        paddr_q <= paddr_d;
        rdata_q <= mem_rdata_i;
    end

    // Fill payload with the global bit of the whole walk merged in
    always_comb begin
        fill_entry_o         = '0;
        fill_entry_o.vpn     = vpn_q;
        fill_entry_o.pte     = pte;
        fill_entry_o.pte.g   = pte.g | gmap_q;
        fill_entry_o.page_4m = (level_q == LEVEL_1);
    end

    assign fill_o        = {fill_en & walk_d_q, fill_en & ~walk_d_q};
    assign walk_err_o    = {err_en & walk_d_q, err_en & ~walk_d_q};
    assign mem_req_o     = req_q;
    assign mem_paddr_o   = paddr_q;
    assign walk_active_o = (state_q != PTW_IDLE);

endmodule

`default_nettype wire

/* verilog/tlb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_cfg.svh"

module tlb
    import mmu_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush_i,
    input  logic               fill_i,
    input  tlb_entry_t         fill_entry_i,
    input  logic [`VALEN-13:0] lookup_vpn_i,
    output logic               hit_o,
    output tlb_entry_t         hit_entry_o
);

    localparam int PTR_W = (`TLB_ENTRIES > 1) ? $clog2(`TLB_ENTRIES) : 1;

    logic [`TLB_ENTRIES-1:0] valid_q;
    tlb_entry_t              entry_q [`TLB_ENTRIES];
    logic [PTR_W-1:0]        fill_ptr_q;
    logic [`TLB_ENTRIES-1:0] match;

    // Tag compare, a 4 MiB entry only looks at VPN[1]
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (entry_q[i].page_4m) begin
                match[i] = valid_q[i] && (entry_q[i].vpn[19:10] == lookup_vpn_i[19:10]);
            end else begin
                match[i] = valid_q[i] && (entry_q[i].vpn == lookup_vpn_i);
            end
        end
    end

    // Lowest matching slot wins
    always_comb begin
        hit_o       = |match;
        hit_entry_o = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_entry_o = entry_q[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= '0;
            fill_ptr_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_ptr_q] <= 1'b1;
            // Round-robin replacement
            if (fill_ptr_q == PTR_W'(`TLB_ENTRIES - 1)) begin
                fill_ptr_q <= '0;
            end else begin
                fill_ptr_q <= fill_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i && !flush_i) begin
            entry_q[fill_ptr_q] <= fill_entry_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/mmu_pkg.sv */
`default_nettype none

`include "mmu_cfg.svh"

package mmu_pkg;

    // Sv32 page table entry, V sits in bit 0
    typedef struct packed {
        logic [`PPN_W-1:0] ppn;
        logic [1:0]        rsw;
        logic              d;
        logic              a;
        logic              g;
        logic              u;
        logic              x;
        logic              w;
        logic              r;
        logic              v;
    } pte_sv32_t;

    // Walker FSM states
    typedef enum logic [1:0] {
        PTW_IDLE         = 2'd0,
        PTW_PROCESS_PTE  = 2'd1,
        PTW_PAGE_ERR     = 2'd2,
        PTW_WAIT_R_VALID = 2'd3
    } ptw_state_e;

    // Level 1 is the root table, level 2 the leaf table
    typedef enum logic {
        LEVEL_1 = 1'b0,
        LEVEL_2 = 1'b1
    } ptw_level_e;

    // What the walker writes into a TLB slot
    typedef struct packed {
        logic [`VALEN-13:0] vpn;
        pte_sv32_t          pte;
        logic               page_4m;
    } tlb_entry_t;

endpackage

`default_nettype wire

/* include/mmu_cfg.svh */
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// Sv32 virtual address width
`define VALEN 32

// Sv32 physical address width, 22-bit PPN plus 12-bit offset
`define PALEN 34

// Data width of the page table read port
`define XLEN 32

// Physical page number width
`define PPN_W 22

// Entries in each TLB
`define TLB_ENTRIES 4

// Translation ports, 0 is instruction and 1 is data
`define NUM_PORTS 2

`endif
